/* fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

////////////////////////////////////////
// fetch geometry
////////////////////////////////////////

// instruction slots per fetch bundle
`define FETCH_WIDTH 4

// instruction word and pc width
`define INST_W 16

////////////////////////////////////////
// branch control limits
////////////////////////////////////////

// unresolved branches allowed in flight
`define MAX_INFLIGHT 2

// two-bit counters in the predictor table
`define BPRED_DEPTH 16

`endif

/* fetch_pkg.sv */
`include "fetch_defines.svh"

package fetch_pkg;

   ////////////////////////////////////////
   // instruction word views
   ////////////////////////////////////////

   // conditional branch layout
   typedef struct packed {
      logic [1:0]  major;
      logic [1:0]  cond;
      logic [11:0] offset;
   } br_view_t;

   // jump layout, opcode all ones marks a jump
   typedef struct packed {
      logic [3:0] opcode;
      logic [9:0] target;
      logic [1:0] mode;
   } jmp_view_t;

   // one word, read either way by the classifier
   typedef union packed {
      br_view_t  br;
      jmp_view_t jmp;
   } inst_word_t;

   ////////////////////////////////////////
   // bundle and per-slot decode
   ////////////////////////////////////////

   // slot 0 is the oldest instruction
   typedef struct packed {
      logic [`INST_W-1:0]                 pc;
      inst_word_t [`FETCH_WIDTH-1:0]      slot;
   } fetch_bundle_t;

   // one bit per slot in each vector
   typedef struct packed {
      logic [`FETCH_WIDTH-1:0] is_jump;
      logic [`FETCH_WIDTH-1:0] is_imm_jump;
      logic [`FETCH_WIDTH-1:0] is_branch;
   } slot_class_t;

endpackage

/* ctrl_pkg.sv */
`include "fetch_defines.svh"

package ctrl_pkg;

   // predictor index width, from table depth
   localparam int unsigned BPRED_IDX_W = $clog2(`BPRED_DEPTH);

   ////////////////////////////////////////
   // feedback from the reorder buffer
   ////////////////////////////////////////

   typedef struct packed {
      logic                   decr;
      logic                   two;
      logic                   train;
      logic [BPRED_IDX_W-1:0] train_idx;
      logic                   train_taken;
   } commit_t;

   // predicted direction per slot
   typedef struct packed {
      logic [`FETCH_WIDTH-1:0] taken;
   } pred_t;

   ////////////////////////////////////////
   // handler result
   ////////////////////////////////////////

   typedef struct packed {
      logic [`FETCH_WIDTH-1:0][`INST_W-1:0] words;
      logic [`FETCH_WIDTH-1:0]              taken_mask;
      logic [`FETCH_WIDTH-1:0]              imm_mask;
      logic [`INST_W-1:0]                   next_pc;
      logic                                 redirect;
      logic                                 branch_full;
   } fetch_out_t;

endpackage

/* slot_classifier.sv */
`include "fetch_defines.svh"

module slot_classifier (
   input  fetch_pkg::fetch_bundle_t bundle,
   output fetch_pkg::slot_class_t   cls
);

   ////////////////////////////////////////
   // per-slot decode
   ////////////////////////////////////////

   always_comb begin
      fetch_pkg::inst_word_t w;
      cls = '0;
      w   = '0;
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         w = bundle.slot[i];
         // jump: opcode nibble all ones
         cls.is_jump[i]     = &w.jmp.opcode;
         // immediate form when mode field is zero
         cls.is_imm_jump[i] = (&w.jmp.opcode) && (w.jmp.mode == 2'b00);
         // branch: major 10 with a real condition
         // cond 00 is not a branch
         cls.is_branch[i]   = (w.br.major == 2'b10) && (w.br.cond != 2'b00);
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   // the two views must never claim the same slot
   always_comb begin
      assert ((cls.is_jump & cls.is_branch) == '0)
         else $error("slot marked both jump and branch");
   end

endmodule

/* branch_predictor.sv */
`include "fetch_defines.svh"

module branch_predictor (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [`INST_W-1:0]  pc,
   input  ctrl_pkg::commit_t   commit,
   output ctrl_pkg::pred_t     pred
);

   localparam int unsigned IDX_W = ctrl_pkg::BPRED_IDX_W;

   // two-bit saturating counters
   // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
   logic [1:0] cnt [`BPRED_DEPTH];

   // table index per slot
   logic [IDX_W-1:0] rd_idx [`FETCH_WIDTH];

   ////////////////////////////////////////
   // read side
   ////////////////////////////////////////

   // consecutive indexes from the bundle pc, wrap in the table
   always_comb begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         rd_idx[i] = pc[IDX_W-1:0] + IDX_W'(i);
      end
   end

   // msb of the counter is the taken guess
   always_comb begin
      pred = '0;
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         pred.taken[i] = cnt[rd_idx[i]][1];
      end
   end

   ////////////////////////////////////////
   // training
   ////////////////////////////////////////

   // step toward the resolved direction
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // weakly not taken everywhere
         for (int k = 0; k < `BPRED_DEPTH; k++) begin
            cnt[k] <= 2'b01;
         end
      end else if (commit.train) begin
         if (commit.train_taken) begin
            // saturate at 11
            if (cnt[commit.train_idx] != 2'b11) begin
               cnt[commit.train_idx] <= cnt[commit.train_idx] + 2'd1;
            end
         end else begin
            // saturate at 00
            if (cnt[commit.train_idx] != 2'b00) begin
               cnt[commit.train_idx] <= cnt[commit.train_idx] - 2'd1;
            end
         end
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   // training strobe from the rob must carry a valid index
   a_train_idx_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      commit.train |-> !$isunknown(commit.train_idx)
   ) else $error("train strobe with unknown index");

endmodule

/* branch_handler.sv */
`include "fetch_defines.svh"

module branch_handler (
   input  logic                     clk,
   input  logic                     rst_n,
   input  fetch_pkg::fetch_bundle_t bundle,
   input  fetch_pkg::slot_class_t   cls,
   input  ctrl_pkg::pred_t          pred,
   input  logic                     stall_fetch,
   input  ctrl_pkg::commit_t        commit,
   output ctrl_pkg::fetch_out_t     result
);

   localparam int unsigned FW    = `FETCH_WIDTH;
   localparam int unsigned MAX   = `MAX_INFLIGHT;
   // in-flight count register width
   localparam int unsigned CNT_W = $clog2(MAX + 1);
   // room for count plus a full bundle of branches
   localparam int unsigned SUM_W = $clog2(MAX + FW + 1);
   // kept slot count width
   localparam int unsigned SLT_W = $clog2(FW + 1);

   // registered state
   logic [CNT_W-1:0] count_q;
   logic [CNT_W-1:0] count_d;
   logic             hold_q;
   logic             hold_d;

   // flush chain results
   logic [FW-1:0]    flush;
   logic [FW-1:0]    taken;
   logic             limit_hit;
   logic             blocked;
   logic [SLT_W-1:0] kept_slots;
   logic [SUM_W-1:0] inc_sum;

   // kept branches ahead of each slot, last entry is the bundle total
   logic [SUM_W-1:0] kb_pre [FW+1];

   ////////////////////////////////////////
   // flush chain
   ////////////////////////////////////////

   // whole bundle dropped on stall or while the limit is held
   assign blocked = stall_fetch | hold_q;

   always_comb begin
      logic prev_cut;
      prev_cut  = 1'b0;
      flush     = '0;
      taken     = '0;
      limit_hit = 1'b0;
      kb_pre[0] = '0;
      for (int i = 0; i < FW; i++) begin
         if (blocked) begin
            flush[i] = 1'b1;
         end else if (prev_cut) begin
            // older slot flushed, jumped or was taken
            flush[i] = 1'b1;
         end else if (cls.is_branch[i] &&
                      (SUM_W'(count_q) + kb_pre[i] >= SUM_W'(MAX))) begin
            // one branch too many
            flush[i]  = 1'b1;
            limit_hit = 1'b1;
         end
         // taken only for a kept branch
         taken[i]    = !flush[i] && cls.is_branch[i] && pred.taken[i];
         kb_pre[i+1] = kb_pre[i] + SUM_W'(!flush[i] && cls.is_branch[i]);
         // anything after this slot goes
         prev_cut    = flush[i] | cls.is_jump[i] | taken[i];
      end
   end

   ////////////////////////////////////////
   // in-flight count and hold
   ////////////////////////////////////////

   assign inc_sum = SUM_W'(count_q) + kb_pre[FW];

   always_comb begin
      if (commit.decr && (count_q != '0)) begin
         // rob release wins over new branches
         if (commit.two) begin
            count_d = (count_q >= CNT_W'(2)) ? count_q - CNT_W'(2) : '0;
         end else begin
            count_d = count_q - CNT_W'(1);
         end
      end else if (inc_sum > SUM_W'(MAX)) begin
         count_d = CNT_W'(MAX);
      end else begin
         count_d = inc_sum[CNT_W-1:0];
      end
   end

   // set by a limit flush, cleared by any release
   always_comb begin
      if (commit.decr) begin
         hold_d = 1'b0;
      end else if (limit_hit) begin
         hold_d = 1'b1;
      end else begin
         hold_d = hold_q;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count_q <= '0;
         hold_q  <= 1'b0;
      end else begin
         count_q <= count_d;
         hold_q  <= hold_d;
      end
   end

   ////////////////////////////////////////
   // result
   ////////////////////////////////////////

   // flush is a suffix, so kept slots are a prefix of the bundle
   assign kept_slots = SLT_W'($countones(~flush));

   always_comb begin
      result = '0;
      for (int i = 0; i < FW; i++) begin
         // flushed slot becomes a nop
         result.words[i] = flush[i] ? '0 : bundle.slot[i];
      end
      result.taken_mask  = taken;
      result.imm_mask    = ~flush & cls.is_imm_jump;
      // sequential pc past the kept slots
      result.next_pc     = bundle.pc + `INST_W'(kept_slots);
      // a kept jump or taken branch is always the last kept slot
      result.redirect    = |(~flush & (cls.is_jump | taken));
      result.branch_full = hold_q;
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   // limit holds across commits and increments
   a_count_bound : assert property (
      @(posedge clk) disable iff (!rst_n)
      count_q <= CNT_W'(MAX)
   ) else $error("in-flight count above limit");

   // hold from a past cycle must nop the whole bundle
   a_hold_nops : assert property (
      @(posedge clk) disable iff (!rst_n)
      hold_q |-> (result.words == '0)
   ) else $error("words passed while branch limit held");

endmodule

/* fetch_branch_top.sv */
module fetch_branch_top (
   input  logic                     clk,
   input  logic                     rst_n,
   input  fetch_pkg::fetch_bundle_t bundle,
   input  logic                     stall_fetch,
   input  ctrl_pkg::commit_t        commit,
   output ctrl_pkg::fetch_out_t     result
);

   // decode flags to the handler
   fetch_pkg::slot_class_t cls;

   // counter msbs to the handler
   ctrl_pkg::pred_t pred;

   ////////////////////////////////////////
   // side by side on the bundle
   ////////////////////////////////////////

   slot_classifier u_slot_classifier (
      .bundle (bundle),
      .cls    (cls)
   );

   // indexed from the bundle pc, trained by the rob
   branch_predictor u_branch_predictor (
      .clk    (clk),
      .rst_n  (rst_n),
      .pc     (bundle.pc),
      .commit (commit),
      .pred   (pred)
   );

   ////////////////////////////////////////
   // combine
   ////////////////////////////////////////

   branch_handler u_branch_handler (
      .clk         (clk),
      .rst_n       (rst_n),
      .bundle      (bundle),
      .cls         (cls),
      .pred        (pred),
      .stall_fetch (stall_fetch),
      .commit      (commit),
      .result      (result)
   );

endmodule

/* tb_fetch_branch.sv */
`include "fetch_defines.svh"

module tb_fetch_branch;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int FW       = `FETCH_WIDTH;
   localparam int IW       = `INST_W;
   localparam int N_RANDOM = 200;
   // reset, table rows, random bundles and some slack
   localparam int WATCHDOG_CYCLES = 8 + 24 + N_RANDOM + 20;

   // common rob feedback values
   localparam ctrl_pkg::commit_t NO_CMT  = '0;
   localparam ctrl_pkg::commit_t DEC_ONE = '{decr: 1'b1, default: 0};
   localparam ctrl_pkg::commit_t DEC_TWO = '{decr: 1'b1, two: 1'b1, default: 0};

   // one directed step, keep is the number of slots that survive
   typedef struct packed {
      fetch_pkg::fetch_bundle_t bundle;
      logic                     stall;
      ctrl_pkg::commit_t        commit;
      logic [2:0]               keep;
      logic [FW-1:0]            taken;
      logic [FW-1:0]            imm;
      logic [IW-1:0]            next_pc;
      logic                     redirect;
      logic                     full;
   } row_t;

   logic                     clk;
   logic                     rst_n;
   fetch_pkg::fetch_bundle_t bundle;
   logic                     stall_fetch;
   ctrl_pkg::commit_t        commit;
   ctrl_pkg::fetch_out_t     result;

   row_t   rows [$];
   int     errors;
   integer seed;

   // reference state
   int         ref_count;
   logic       ref_hold;
   logic [1:0] ref_cnt [`BPRED_DEPTH];

   fetch_branch_top UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .bundle      (bundle),
      .stall_fetch (stall_fetch),
      .commit      (commit),
      .result      (result)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////
   // table and helpers
   ////////////////////////////////////////

   function automatic ctrl_pkg::commit_t train_cmt(input logic [3:0] idx, input logic tk);
      ctrl_pkg::commit_t c;
      c             = '0;
      c.train       = 1'b1;
      c.train_idx   = idx;
      c.train_taken = tk;
      return c;
   endfunction

   task automatic add_row(input logic [IW-1:0] pc, input logic [FW*IW-1:0] words,
                          input logic stall, input ctrl_pkg::commit_t c, input int keep,
                          input logic [FW-1:0] tk, input logic [FW-1:0] imm,
                          input logic [IW-1:0] npc, input logic redir, input logic full);
      row_t r;
      r.bundle.pc   = pc;
      r.bundle.slot = words;
      r.stall       = stall;
      r.commit      = c;
      r.keep        = 3'(keep);
      r.taken       = tk;
      r.imm         = imm;
      r.next_pc     = npc;
      r.redirect    = redir;
      r.full        = full;
      rows.push_back(r);
   endtask

   // words are slot 3 down to slot 0
   task automatic load_table();
      // all-zero bundle after reset
      add_row('h0000, 64'h0000_0000_0000_0000, 0, NO_CMT, 4, 'h0, 'h0, 'h0004, 0, 0);
      // jump in slot 1, immediate then register form
      add_row('h0100, 64'h4444_3333_F010_2222, 0, NO_CMT, 2, 'h0, 'h2, 'h0102, 1, 0);
      add_row('h0100, 64'h4444_3333_F011_2222, 0, NO_CMT, 2, 'h0, 'h0, 'h0102, 1, 0);
      // counter 5 up to strong taken
      add_row('h0200, 64'h4444_3333_2222_1234, 0, train_cmt(5, 1), 4, 'h0, 'h0, 'h0204, 0, 0);
      add_row('h0200, 64'h4444_3333_2222_1234, 0, train_cmt(5, 1), 4, 'h0, 'h0, 'h0204, 0, 0);
      // taken branch at index 5 cuts slots 2 and 3
      add_row('h0204, 64'h4444_3333_9123_2222, 0, NO_CMT, 2, 'h2, 'h0, 'h0206, 1, 0);
      // weak counter, branch falls through
      add_row('h0300, 64'h4444_3333_9123_2222, 0, NO_CMT, 4, 'h0, 'h0, 'h0304, 0, 0);
      add_row('h0400, 64'h4444_3333_2222_1234, 0, DEC_TWO, 4, 'h0, 'h0, 'h0404, 0, 0);
      // three branches from an empty window
      add_row('h0500, 64'h2222_B003_A002_9001, 0, NO_CMT, 2, 'h0, 'h0, 'h0502, 0, 0);
      // limit held, resend is dropped
      add_row('h0502, 64'h5555_4444_2222_B003, 0, NO_CMT, 0, 'h0, 'h0, 'h0502, 0, 1);
      add_row('h0502, 64'h5555_4444_2222_B003, 0, NO_CMT, 0, 'h0, 'h0, 'h0502, 0, 1);
      add_row('h0502, 64'h5555_4444_2222_B003, 0, DEC_TWO, 0, 'h0, 'h0, 'h0502, 0, 1);
      add_row('h0502, 64'h5555_4444_2222_B003, 0, NO_CMT, 4, 'h0, 'h0, 'h0506, 0, 0);
      // one in flight, second branch over the limit
      add_row('h0600, 64'h3333_2222_A002_9001, 0, NO_CMT, 1, 'h0, 'h0, 'h0601, 0, 0);
      add_row('h0601, 64'h1234_3333_2222_A002, 0, DEC_ONE, 0, 'h0, 'h0, 'h0601, 0, 1);
      add_row('h0601, 64'h1234_3333_2222_A002, 0, NO_CMT, 4, 'h0, 'h0, 'h0605, 0, 0);
      add_row('h0700, 64'h4444_3333_2222_1234, 0, DEC_TWO, 4, 'h0, 'h0, 'h0704, 0, 0);
      // stalled branches are not counted
      add_row('h0800, 64'h4444_A002_2222_9001, 1, NO_CMT, 0, 'h0, 'h0, 'h0800, 0, 0);
      add_row('h0800, 64'h4444_A002_2222_9001, 0, NO_CMT, 4, 'h0, 'h0, 'h0804, 0, 0);
      // stall at full count, no hold
      add_row('h0900, 64'h2222_9001_1234_3333, 1, NO_CMT, 0, 'h0, 'h0, 'h0900, 0, 0);
      add_row('h0A00, 64'h4444_3333_2222_1234, 0, DEC_TWO, 4, 'h0, 'h0, 'h0A04, 0, 0);
      // counter 5 steps back down
      add_row('h0B00, 64'h4444_3333_2222_F010, 0, train_cmt(5, 0), 1, 'h0, 'h1, 'h0B01, 1, 0);
      add_row('h0C05, 64'h4444_3333_2222_9123, 0, train_cmt(5, 0), 1, 'h1, 'h0, 'h0C06, 1, 0);
      add_row('h0C05, 64'h4444_3333_2222_9123, 0, NO_CMT, 4, 'h0, 'h0, 'h0C09, 0, 0);
   endtask

   function automatic ctrl_pkg::fetch_out_t row_expect(input row_t r);
      ctrl_pkg::fetch_out_t e;
      e = '0;
      for (int i = 0; i < FW; i++) begin
         if (i < int'(r.keep)) begin
            e.words[i] = r.bundle.slot[i];
         end
      end
      e.taken_mask  = r.taken;
      e.imm_mask    = r.imm;
      e.next_pc     = r.next_pc;
      e.redirect    = r.redirect;
      e.branch_full = r.full;
      return e;
   endfunction

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   task automatic model_eval(input fetch_pkg::fetch_bundle_t b, input logic stall,
                             output ctrl_pkg::fetch_out_t e, output int nb, output logic lim);
      logic [IW-1:0] w;
      logic [3:0]    idx;
      logic          cut;
      logic          jmp;
      logic          br;
      logic          tk;
      int            kept;
      e    = '0;
      nb   = 0;
      lim  = 1'b0;
      kept = 0;
      cut  = stall | ref_hold;
      for (int i = 0; i < FW; i++) begin
         w   = b.slot[i];
         jmp = (w[15:12] == 4'hf);
         br  = (w[15:14] == 2'b10) && (w[13:12] != 2'b00);
         idx = b.pc[3:0] + 4'(i);
         tk  = ref_cnt[idx][1];
         // window already full at this branch
         if (!cut && br && (ref_count + nb >= `MAX_INFLIGHT)) begin
            cut = 1'b1;
            lim = 1'b1;
         end
         if (!cut) begin
            e.words[i]      = w;
            kept            = kept + 1;
            nb              = nb + int'(br);
            e.taken_mask[i] = br && tk;
            e.imm_mask[i]   = jmp && (w[1:0] == 2'b00);
            // younger slots go after a jump or taken branch
            if (jmp || (br && tk)) begin
               e.redirect = 1'b1;
               cut        = 1'b1;
            end
         end
      end
      e.next_pc     = b.pc + IW'(kept);
      e.branch_full = ref_hold;
   endtask

   task automatic model_step(input ctrl_pkg::commit_t c, input int nb, input logic lim);
      if (c.decr && (ref_count != 0)) begin
         ref_count = (c.two && (ref_count >= 2)) ? ref_count - 2 :
                     (c.two ? 0 : ref_count - 1);
      end else begin
         ref_count = (ref_count + nb > `MAX_INFLIGHT) ? `MAX_INFLIGHT : ref_count + nb;
      end
      if (c.decr) begin
         ref_hold = 1'b0;
      end else if (lim) begin
         ref_hold = 1'b1;
      end
      if (c.train && c.train_taken && (ref_cnt[c.train_idx] != 2'b11)) begin
         ref_cnt[c.train_idx] = ref_cnt[c.train_idx] + 2'd1;
      end else if (c.train && !c.train_taken && (ref_cnt[c.train_idx] != 2'b00)) begin
         ref_cnt[c.train_idx] = ref_cnt[c.train_idx] - 2'd1;
      end
   endtask

   ////////////////////////////////////////
   // random stimulus and checking
   ////////////////////////////////////////

   // biased toward jumps and branches
   function automatic logic [IW-1:0] rand_word();
      logic [31:0] r;
      logic [15:0] w;
      r = $random(seed);
      w = r[31:16];
      if (r[2:0] < 3'd2) begin
         w[15:12] = 4'hf;
      end else if (r[2:0] < 3'd5) begin
         w[15:14] = 2'b10;
      end
      return w;
   endfunction

   function automatic ctrl_pkg::commit_t rand_commit();
      logic [31:0]       r;
      ctrl_pkg::commit_t c;
      r             = $random(seed);
      c.decr        = (r[1:0] == 2'b00);
      c.two         = r[2];
      c.train       = r[3];
      c.train_idx   = r[7:4];
      c.train_taken = r[8];
      return c;
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      errors = errors + 1;
      $display("ERROR at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
   endtask

   task automatic compare_result(input ctrl_pkg::fetch_out_t exp);
      if (result.words !== exp.words)
         report_mismatch("words", exp.words, result.words);
      if (result.taken_mask !== exp.taken_mask)
         report_mismatch("taken_mask", exp.taken_mask, result.taken_mask);
      if (result.imm_mask !== exp.imm_mask)
         report_mismatch("imm_mask", exp.imm_mask, result.imm_mask);
      if (result.next_pc !== exp.next_pc)
         report_mismatch("next_pc", exp.next_pc, result.next_pc);
      if (result.redirect !== exp.redirect)
         report_mismatch("redirect", exp.redirect, result.redirect);
      if (result.branch_full !== exp.branch_full)
         report_mismatch("branch_full", exp.branch_full, result.branch_full);
   endtask

   initial begin
      ctrl_pkg::fetch_out_t     exp;
      fetch_pkg::fetch_bundle_t b;
      logic [31:0]              r;
      int                       nb;
      logic                     lim;
      errors      = 0;
      seed        = 53133;
      rst_n       = 1'b0;
      bundle      = '0;
      stall_fetch = 1'b0;
      commit      = '0;
      ref_count   = 0;
      ref_hold    = 1'b0;
      for (int k = 0; k < `BPRED_DEPTH; k++) begin
         ref_cnt[k] = 2'b01;
      end
      load_table();
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      // directed rows, outputs checked mid-cycle
      foreach (rows[n]) begin
         @(posedge clk);
         bundle      <= rows[n].bundle;
         stall_fetch <= rows[n].stall;
         commit      <= rows[n].commit;
         @(negedge clk);
         compare_result(row_expect(rows[n]));
         model_eval(bundle, stall_fetch, exp, nb, lim);
         model_step(commit, nb, lim);
      end
      // random bundles against the model
      for (int n = 0; n < N_RANDOM; n++) begin
         b.pc = 16'($random(seed));
         for (int i = 0; i < FW; i++) begin
            b.slot[i] = rand_word();
         end
         r = $random(seed);
         @(posedge clk);
         bundle      <= b;
         stall_fetch <= (r[2:0] == 3'b000);
         commit      <= rand_commit();
         @(negedge clk);
         model_eval(bundle, stall_fetch, exp, nb, lim);
         compare_result(exp);
         model_step(commit, nb, lim);
      end
      $display("checks done, %0d errors", errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_CYCLES * 10);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $finish;
   end

endmodule

/* sim.f */
+incdir+.
fetch_pkg.sv
ctrl_pkg.sv
slot_classifier.sv
branch_predictor.sv
branch_handler.sv
fetch_branch_top.sv
tb_fetch_branch.sv

/* Makefile */
# Verilator build and run of the fetch branch testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_fetch_branch -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_fetch_branch)"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
